// File: include/muldiv_macros.svh
////////////////////////////////////////////////////////////////////////////
// muldiv unit sizing macros
// operand width and iteration counts of the two engines
////////////////////////////////////////////////////////////////////////////

`ifndef MULDIV_MACROS_SVH
`define MULDIV_MACROS_SVH

// operand and result width, one word
`define MD_XLEN 32

// radix-4 booth retires two multiplier bits per step
`define MD_MUL_STEPS ((`MD_XLEN) / 2)

// restoring divider produces one quotient bit per step
`define MD_DIV_STEPS (`MD_XLEN)

`endif

// File: verilog/muldiv_pkg.sv
////////////////////////////////////////////////////////////////////////////
// muldiv shared types
// operation enum, request struct, engine state enums
////////////////////////////////////////////////////////////////////////////

`include "muldiv_macros.svh"

package muldiv_pkg;

    // funct3 order of the M extension, bit 2 set means divide
    typedef enum logic [2:0] {
        MD_MUL    = 3'b000,  // low word, signed x signed
        MD_MULH   = 3'b001,  // high word, signed x signed
        MD_MULHSU = 3'b010,  // high word, signed x unsigned
        MD_MULHU  = 3'b011,  // high word, unsigned x unsigned
        MD_DIV    = 3'b100,
        MD_DIVU   = 3'b101,
        MD_REM    = 3'b110,
        MD_REMU   = 3'b111
    } md_op_e;

    // request from the execute stage
    // a is multiplicand / dividend, b is multiplier / divisor
    typedef struct packed {
        md_op_e              op;
        logic [`MD_XLEN-1:0] a;
        logic [`MD_XLEN-1:0] b;
    } md_req_t;

    // booth multiplier FSM
    typedef enum logic [1:0] {
        MUL_IDLE   = 2'b00,
        MUL_CALC   = 2'b01,
        MUL_OUTPUT = 2'b10
    } mul_state_e;

    // restoring divider FSM
    typedef enum logic [1:0] {
        DIV_IDLE   = 2'b00,
        DIV_CALC   = 2'b01,
        DIV_OUTPUT = 2'b10
    } div_state_e;

endpackage

// File: verilog/booth_mul.sv
////////////////////////////////////////////////////////////////////////////
// booth_mul
// radix-4 booth multiplier, 16 iterations, MUL/MULH/MULHSU/MULHU
// high word of unsigned forms fixed up after the signed product
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "muldiv_macros.svh"

module booth_mul (
    input  logic                clk,
    input  logic                rst_n,
    input  muldiv_pkg::md_req_t req_i,
    input  logic                start_i,   // level, held for the whole op
    output logic [`MD_XLEN-1:0] result_o,
    output logic                busy_o,
    output logic                valid_o    // one cycle pulse
);

    localparam int XLEN  = `MD_XLEN;
    localparam int FW    = 2 * XLEN + 3;             // partial product frame
    localparam int CNT_W = $clog2(`MD_MUL_STEPS);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`MD_MUL_STEPS - 1);

    muldiv_pkg::mul_state_e state_q;
    muldiv_pkg::mul_state_e state_d;
    logic [CNT_W-1:0]       cnt_q;

    // operands kept for the high word fix-up
    muldiv_pkg::md_op_e     op_q;
    logic [XLEN-1:0]        mcand_q;
    logic [XLEN-1:0]        mplier_q;

    // precomputed addends, aligned to the upper part of the frame
    logic [FW-1:0]          add1_q;
    logic [FW-1:0]          sub1_q;
    logic [FW-1:0]          add2_q;
    logic [FW-1:0]          sub2_q;
    logic [FW-1:0]          prod_q;   // {acc, multiplier, guard}

    logic [XLEN+1:0]        mcand_x1;
    logic [XLEN+1:0]        mcand_x2;
    logic [FW-1:0]          addend;
    logic [FW-1:0]          prod_sum;
    logic [XLEN-1:0]        prod_hi;
    logic [XLEN-1:0]        prod_lo;
    logic [XLEN-1:0]        fix_mcand;
    logic [XLEN-1:0]        fix_mplier;
    logic [XLEN-1:0]        mul_res;

    assign mcand_x1 = {{2{req_i.a[XLEN-1]}}, req_i.a};      // 1x, sign extended
    assign mcand_x2 = {req_i.a[XLEN-1], req_i.a, 1'b0};     // 2x

    // recode the low three bits of the partial product
    always_comb begin
        case (prod_q[2:0])
            3'b001, 3'b010: addend = add1_q;
            3'b011:         addend = add2_q;
            3'b100:         addend = sub2_q;
            3'b101, 3'b110: addend = sub1_q;
            default:        addend = '0;   // 000 / 111, nothing to add
        endcase
        prod_sum = prod_q + addend;
    end

    assign prod_hi = prod_q[2*XLEN:XLEN+1];
    assign prod_lo = prod_q[XLEN:1];

    // signed product took b as negative when its msb is set, add a back
    assign fix_mcand  = mplier_q[XLEN-1] ? mcand_q : '0;
    // same for a when both sides are unsigned
    assign fix_mplier = mcand_q[XLEN-1] ? mplier_q : '0;

    always_comb begin
        case (op_q)
            muldiv_pkg::MD_MULH:   mul_res = prod_hi;
            muldiv_pkg::MD_MULHSU: mul_res = prod_hi + fix_mcand;
            muldiv_pkg::MD_MULHU:  mul_res = prod_hi + fix_mcand + fix_mplier;
            default:               mul_res = prod_lo;   // MUL
        endcase
    end

    // next state, a low start always drops back to idle
    always_comb begin
        state_d = state_q;
        if (!start_i) begin
            state_d = muldiv_pkg::MUL_IDLE;
        end else begin
            case (state_q)
                muldiv_pkg::MUL_IDLE:   state_d = muldiv_pkg::MUL_CALC;
                muldiv_pkg::MUL_CALC: begin
                    if (cnt_q == LAST_STEP) state_d = muldiv_pkg::MUL_OUTPUT;
                end
                default:                state_d = muldiv_pkg::MUL_IDLE;
            endcase
        end
    end

    // control and result
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q  <= muldiv_pkg::MUL_IDLE;
            cnt_q    <= '0;
            busy_o   <= 1'b0;
            valid_o  <= 1'b0;
            result_o <= '0;
        end else begin
            state_q <= state_d;
            valid_o <= 1'b0;
            case (state_q)
                muldiv_pkg::MUL_IDLE: begin
                    busy_o <= start_i;
                    cnt_q  <= '0;
                end
                muldiv_pkg::MUL_CALC: cnt_q <= cnt_q + 1'b1;
                muldiv_pkg::MUL_OUTPUT: begin
                    if (start_i) begin   // aborted op gives no pulse
                        result_o <= mul_res;
                        valid_o  <= 1'b1;
                        busy_o   <= 1'b0;
                    end
                end
                default: busy_o <= 1'b0;
            endcase
        end
    end

    // operand capture and booth iteration
    always_ff @(posedge clk) begin
        if (state_q == muldiv_pkg::MUL_IDLE && start_i) begin
            op_q     <= req_i.op;
            mcand_q  <= req_i.a;
            mplier_q <= req_i.b;
            add1_q   <= {mcand_x1, {(XLEN + 1){1'b0}}};
            sub1_q   <= {-mcand_x1, {(XLEN + 1){1'b0}}};
            add2_q   <= {mcand_x2, {(XLEN + 1){1'b0}}};
            sub2_q   <= {-mcand_x2, {(XLEN + 1){1'b0}}};
            prod_q   <= {{(XLEN + 2){1'b0}}, req_i.b, 1'b0};
        end else if (state_q == muldiv_pkg::MUL_CALC) begin
            prod_q <= {{2{prod_sum[FW-1]}}, prod_sum[FW-1:2]};   // asr by 2
        end
    end

endmodule

// File: verilog/restoring_div.sv
////////////////////////////////////////////////////////////////////////////
// restoring_div
// sign-magnitude restoring divider, 32 iterations, DIV/DIVU/REM/REMU
// zero divisor and signed overflow results per the M extension
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "muldiv_macros.svh"

module restoring_div (
    input  logic                clk,
    input  logic                rst_n,
    input  muldiv_pkg::md_req_t req_i,
    input  logic                start_i,   // level, held for the whole op
    output logic [`MD_XLEN-1:0] result_o,
    output logic                busy_o,
    output logic                valid_o    // one cycle pulse
);

    localparam int XLEN  = `MD_XLEN;
    localparam int CNT_W = $clog2(`MD_DIV_STEPS);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`MD_DIV_STEPS - 1);
    localparam logic [XLEN-1:0]  MOST_NEG  = {1'b1, {(XLEN - 1){1'b0}}};

    muldiv_pkg::div_state_e state_q;
    muldiv_pkg::div_state_e state_d;
    logic [CNT_W-1:0]       cnt_q;

    // per-op flags recorded at start
    logic                   want_rem_q;
    logic                   neg_quo_q;
    logic                   neg_rem_q;
    logic                   div_zero_q;
    logic                   ovf_q;
    logic [XLEN-1:0]        dividend_q;   // raw, for the zero divisor case
    logic [XLEN-1:0]        divisor_q;    // magnitude
    logic [XLEN-1:0]        rem_q;
    logic [XLEN-1:0]        quo_q;        // dividend bits shift out, quotient in

    logic                   is_signed;
    logic                   a_neg;
    logic                   b_neg;
    logic [XLEN-1:0]        a_mag;
    logic [XLEN-1:0]        b_mag;
    logic [XLEN:0]          shift_pair;
    logic [XLEN+1:0]        trial;
    logic                   trial_ok;
    logic [XLEN-1:0]        quo_sgn;
    logic [XLEN-1:0]        rem_sgn;
    logic [XLEN-1:0]        div_res;

    // decode of the incoming request
    assign is_signed = ~req_i.op[0];                      // DIV, REM
    assign a_neg     = is_signed & req_i.a[XLEN-1];
    assign b_neg     = is_signed & req_i.b[XLEN-1];
    assign a_mag     = a_neg ? -req_i.a : req_i.a;
    assign b_mag     = b_neg ? -req_i.b : req_i.b;

    // one restoring step
    assign shift_pair = {rem_q, quo_q[XLEN-1]};
    assign trial      = {1'b0, shift_pair} - {2'b00, divisor_q};
    assign trial_ok   = ~trial[XLEN+1];                   // no borrow

    // sign restore and architectural overrides
    assign quo_sgn = neg_quo_q ? -quo_q : quo_q;
    assign rem_sgn = neg_rem_q ? -rem_q : rem_q;

    always_comb begin
        if (div_zero_q) begin
            div_res = want_rem_q ? dividend_q : '1;
        end else if (ovf_q) begin
            div_res = want_rem_q ? '0 : MOST_NEG;
        end else begin
            div_res = want_rem_q ? rem_sgn : quo_sgn;
        end
    end

    // next state, a low start always drops back to idle
    always_comb begin
        state_d = state_q;
        if (!start_i) begin
            state_d = muldiv_pkg::DIV_IDLE;
        end else begin
            case (state_q)
                muldiv_pkg::DIV_IDLE:   state_d = muldiv_pkg::DIV_CALC;
                muldiv_pkg::DIV_CALC: begin
                    if (cnt_q == LAST_STEP) state_d = muldiv_pkg::DIV_OUTPUT;
                end
                default:                state_d = muldiv_pkg::DIV_IDLE;
            endcase
        end
    end

    // control and result
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q  <= muldiv_pkg::DIV_IDLE;
            cnt_q    <= '0;
            busy_o   <= 1'b0;
            valid_o  <= 1'b0;
            result_o <= '0;
        end else begin
            state_q <= state_d;
            valid_o <= 1'b0;
            case (state_q)
                muldiv_pkg::DIV_IDLE: begin
                    busy_o <= start_i;
                    cnt_q  <= '0;
                end
                muldiv_pkg::DIV_CALC: cnt_q <= cnt_q + 1'b1;
                muldiv_pkg::DIV_OUTPUT: begin
                    if (start_i) begin   // no pulse on abort
                        result_o <= div_res;
                        valid_o  <= 1'b1;
                        busy_o   <= 1'b0;
                    end
                end
                default: busy_o <= 1'b0;
            endcase
        end
    end

    // operand capture and shift-subtract loop
    always_ff @(posedge clk) begin
        if (state_q == muldiv_pkg::DIV_IDLE && start_i) begin
            want_rem_q <= req_i.op[1];                    // REM, REMU
            neg_quo_q  <= a_neg ^ b_neg;
            neg_rem_q  <= a_neg;                          // follows dividend
            div_zero_q <= (req_i.b == '0);
            ovf_q      <= is_signed && (req_i.a == MOST_NEG) && (req_i.b == '1);
            dividend_q <= req_i.a;
            divisor_q  <= b_mag;
            rem_q      <= '0;
            quo_q      <= a_mag;
        end else if (state_q == muldiv_pkg::DIV_CALC) begin
            rem_q <= trial_ok ? trial[XLEN-1:0] : shift_pair[XLEN-1:0];
            quo_q <= {quo_q[XLEN-2:0], trial_ok};
        end
    end

endmodule

// File: verilog/muldiv_unit.sv
////////////////////////////////////////////////////////////////////////////
// muldiv_unit
// M extension execute unit, steers start to the booth multiplier or
// the restoring divider and merges busy, valid and result
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "muldiv_macros.svh"

module muldiv_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  muldiv_pkg::md_req_t req_i,
    input  logic                start_i,   // hold high until valid_o
    output logic [`MD_XLEN-1:0] result_o,
    output logic                busy_o,
    output logic                valid_o
);

    logic                is_div;
    logic                mul_start;
    logic                div_start;
    logic [`MD_XLEN-1:0] mul_result;
    logic [`MD_XLEN-1:0] div_result;
    logic                mul_busy;
    logic                div_busy;
    logic                mul_valid;
    logic                div_valid;
    logic [`MD_XLEN-1:0] result_q;   // last delivered result

    // op bit 2 picks the engine
    assign is_div    = req_i.op[2];
    assign mul_start = start_i & ~is_div;
    assign div_start = start_i & is_div;

    booth_mul u_mul (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_i    (req_i),
        .start_i  (mul_start),
        .result_o (mul_result),
        .busy_o   (mul_busy),
        .valid_o  (mul_valid)
    );

    restoring_div u_div (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_i    (req_i),
        .start_i  (div_start),
        .result_o (div_result),
        .busy_o   (div_busy),
        .valid_o  (div_valid)
    );

    assign busy_o  = mul_busy | div_busy;
    assign valid_o = mul_valid | div_valid;   // no extra stage on valid

    // keep the last result visible between pulses
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_q <= '0;
        end else if (mul_valid) begin
            result_q <= mul_result;
        end else if (div_valid) begin
            result_q <= div_result;
        end
    end

    // result lines up with the valid pulse
    always_comb begin
        if (mul_valid) result_o = mul_result;
        else if (div_valid) result_o = div_result;
        else result_o = result_q;
    end

endmodule

// File: bench/muldiv_tb.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the multiply/divide unit
// xorshift and corner operands, reference model from 64-bit products
// and the M extension division rules, latency, abort and idle checks
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "muldiv_macros.svh"

module muldiv_tb;

    localparam int XLEN    = `MD_XLEN;
    localparam int TIMEOUT = 60;   // cycles allowed for one valid pulse
    localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN - 1){1'b0}}};

    logic                clk;
    logic                rst_n;
    muldiv_pkg::md_req_t req;
    logic                start;
    logic [XLEN-1:0]     result;
    logic                busy;
    logic                valid;

    int                  value_errs;
    int                  timeout_errs;
    int                  proto_errs;
    logic [31:0]         rng_state;

    muldiv_unit muldiv_unit_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_i    (req),
        .start_i  (start),
        .result_o (result),
        .busy_o   (busy),
        .valid_o  (valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [XLEN-1:0] next_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // 0, 1, minus one, most negative, most positive
    function automatic logic [XLEN-1:0] corner_value(input int idx);
        case (idx)
            0:       return '0;
            1:       return XLEN'(1);
            2:       return '1;
            3:       return MOST_NEG;
            default: return ~MOST_NEG;
        endcase
    endfunction

    // reference: wide products and the architectural division rules
    function automatic logic [XLEN-1:0] expected_result(input muldiv_pkg::md_op_e op,
                                                        input logic [XLEN-1:0] a,
                                                        input logic [XLEN-1:0] b);
        logic [2*XLEN-1:0]      ext_a;
        logic [2*XLEN-1:0]      ext_b;
        logic [2*XLEN-1:0]      prod;
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic signed [XLEN-1:0] quo_s;
        logic signed [XLEN-1:0] rem_s;
        logic                   ovf;
        sa    = a;
        sb    = b;
        ovf   = (a == MOST_NEG) && (b == '1);
        quo_s = '0;
        rem_s = '0;
        if (b != '0 && !ovf) begin
            quo_s = sa / sb;   // signed, rounds toward zero
            rem_s = sa % sb;   // sign of the dividend
        end
        // a signed except for MULHU, b signed only for MUL and MULH
        ext_a = (op == muldiv_pkg::MD_MULHU) ? {{XLEN{1'b0}}, a} : {{XLEN{a[XLEN-1]}}, a};
        ext_b = (op == muldiv_pkg::MD_MUL || op == muldiv_pkg::MD_MULH) ?
                {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
        prod  = ext_a * ext_b;   // modulo 2^64 is enough
        case (op)
            muldiv_pkg::MD_MUL:  return prod[XLEN-1:0];
            muldiv_pkg::MD_DIV:  return (b == '0) ? '1 : (ovf ? MOST_NEG : quo_s);
            muldiv_pkg::MD_DIVU: return (b == '0) ? '1 : a / b;
            muldiv_pkg::MD_REM:  return (b == '0) ? a : (ovf ? '0 : rem_s);
            muldiv_pkg::MD_REMU: return (b == '0) ? a : a % b;
            default:             return prod[2*XLEN-1:XLEN];   // high word forms
        endcase
    endfunction

    // after an op: no second pulse, busy must settle low
    task automatic wait_idle();
        int   n;
        logic idle;
        n    = 0;
        idle = 1'b0;
        while (!idle && n < 10) begin
            @(posedge clk);
            n++;
            assert (!valid) else begin
                proto_errs++;
                $display("Error at %0t: valid_o pulsed again after the result", $time);
            end
            idle = !busy;
        end
        if (!idle) begin
            proto_errs++;
            $display("busy_o stayed high for 10 cycles after the operation ended");
        end
    endtask

    task automatic run_op(input muldiv_pkg::md_op_e op, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b);
        logic [XLEN-1:0] exp;
        int              lat_exp;
        int              edges;
        logic            seen;
        exp     = expected_result(op, a, b);
        lat_exp = op[2] ? 34 : 18;
        @(posedge clk);
        req.op <= op;
        req.a  <= a;
        req.b  <= b;
        start  <= 1'b1;
        edges  = 0;
        seen   = 1'b0;
        while (!seen && edges < TIMEOUT) begin
            @(posedge clk);
            edges++;   // sampled values come from the previous edge
            if (valid) begin
                seen = 1'b1;
            end else if (edges >= 2) begin
                assert (busy) else begin
                    proto_errs++;
                    $display("Error at %0t: %s busy_o low at edge %0d", $time, op.name(),
                             edges - 1);
                end
            end
        end
        start <= 1'b0;   // dropped at the edge that saw valid
        if (!seen) begin
            timeout_errs++;
            $display("no result from %s a=%h b=%h within %0d cycles", op.name(), a, b,
                     TIMEOUT);
        end else begin
            assert (edges - 1 == lat_exp) else begin
                proto_errs++;
                $display("Error at %0t: %s valid_o after %0d edges, expected %0d", $time,
                         op.name(), edges - 1, lat_exp);
            end
            assert (result === exp) else begin
                value_errs++;
                $display("Error at %0t: %s a=%h b=%h expected %h got %h", $time,
                         op.name(), a, b, exp, result);
            end
        end
        wait_idle();
    endtask

    // drop start mid-op, then the same op must still complete
    task automatic abort_op(input muldiv_pkg::md_op_e op, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b, input int hold);
        int   n;
        logic fell;
        @(posedge clk);
        req.op <= op;
        req.a  <= a;
        req.b  <= b;
        start  <= 1'b1;
        for (n = 0; n < hold; n++) @(posedge clk);
        start <= 1'b0;
        fell = 1'b0;
        for (n = 0; n < 3 && !fell; n++) begin
            @(posedge clk);
            fell = !busy;
        end
        assert (fell) else begin
            proto_errs++;
            $display("Error at %0t: busy_o did not fall within two edges of the abort",
                     $time);
        end
        for (n = 0; n < 40; n++) begin
            @(posedge clk);
            assert (!valid) else begin
                proto_errs++;
                $display("Error at %0t: valid_o after an aborted %s", $time, op.name());
            end
        end
        run_op(op, a, b);
    endtask

    task automatic check_idle();
        int n;
        @(posedge clk);
        assert (!busy && !valid && result == '0) else begin
            value_errs++;
            $display("Error at %0t: after reset busy=%b valid=%b result=%h", $time, busy,
                     valid, result);
        end
        for (n = 0; n < 20; n++) begin
            @(posedge clk);
            assert (!valid) else begin
                proto_errs++;
                $display("Error at %0t: valid_o rose with start_i low", $time);
            end
        end
    endtask

    // every corner pair, then random words
    task automatic run_suite(input muldiv_pkg::md_op_e op);
        int              i;
        int              j;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        for (i = 0; i < 5; i++) begin
            for (j = 0; j < 5; j++) run_op(op, corner_value(i), corner_value(j));
        end
        for (i = 0; i < 12; i++) begin
            a = next_word();
            b = next_word();
            if (op[2] && i[0]) b = b >> a[4:0];   // smaller divisors too
            if (i >= 10) a = corner_value(i - 8); // corner against random
            run_op(op, a, b);
        end
    endtask

    initial begin
        int k;
        rst_n        = 1'b0;
        start        = 1'b0;
        req          = '0;
        value_errs   = 0;
        timeout_errs = 0;
        proto_errs   = 0;
        rng_state    = 32'd23126;
        for (k = 0; k < 10; k++) @(posedge clk);
        rst_n <= 1'b1;
        check_idle();
        for (k = 0; k < 8; k++) run_suite(muldiv_pkg::md_op_e'(k));
        // zero divisor, both signednesses, then signed overflow
        run_op(muldiv_pkg::MD_DIV, next_word(), '0);
        run_op(muldiv_pkg::MD_DIVU, next_word(), '0);
        run_op(muldiv_pkg::MD_REM, next_word(), '0);
        run_op(muldiv_pkg::MD_REMU, next_word(), '0);
        run_op(muldiv_pkg::MD_DIV, MOST_NEG, '1);
        run_op(muldiv_pkg::MD_REM, MOST_NEG, '1);
        abort_op(muldiv_pkg::MD_MULHSU, next_word(), next_word(), 8);
        abort_op(muldiv_pkg::MD_REM, next_word(), next_word() >> 7, 16);
        $display("value errors %0d, timeouts %0d, protocol errors %0d", value_errs,
                 timeout_errs, proto_errs);
        if (value_errs + timeout_errs + proto_errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: muldiv_unit.f
+incdir+include
verilog/muldiv_pkg.sv
verilog/booth_mul.sv
verilog/restoring_div.sv
verilog/muldiv_unit.sv
bench/muldiv_tb.sv

// File: Bender.yml
package:
  name: muldiv_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/muldiv_pkg.sv
      - verilog/booth_mul.sv
      - verilog/restoring_div.sv
      - verilog/muldiv_unit.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/muldiv_tb.sv
